// File: common/e1000_reg_pkg.sv
package e1000_reg_pkg;

	// Register byte offsets, one 32-bit word each
	localparam logic [31:0] REG_EECD = 32'h0000_0010;
	localparam logic [31:0] REG_EERD = 32'h0000_0014;
	localparam logic [31:0] REG_MDIC = 32'h0000_0020;

	// EECD bit-bang pins
	localparam int EECD_SK = 0;
	localparam int EECD_CS = 1;
	localparam int EECD_DI = 2;
	// Live data-out pin, read only
	localparam int EECD_DO = 3;
	// Software request and grant for the pins
	localparam int EECD_REQ = 6;
	localparam int EECD_GNT = 7;

	// EERD fields
	localparam int EERD_START = 0;
	localparam int EERD_DONE = 4;
	// 6-bit word address
	localparam int EERD_ADDR_LO = 8;
	// 16 data bits
	localparam int EERD_DATA_LO = 16;

	// MDIC fields
	localparam int MDIC_DATA_LO = 0;
	localparam int MDIC_REG_LO = 16;
	localparam int MDIC_PHY_LO = 21;
	localparam int MDIC_OP_LO = 26;
	localparam int MDIC_R = 28;
	localparam int MDIC_E = 30;

	// AXI response
	localparam logic [1:0] AXI_OKAY = 2'b00;

endpackage

// File: common/e1000_serial_pkg.sv
package e1000_serial_pkg;

	// aclk cycles per half SK period
	localparam int EE_HALF_DIV = 4;
	localparam int EE_DIV_W = $clog2(EE_HALF_DIV);

	// aclk cycles per half MDC period
	localparam int MDC_HALF_DIV = 4;
	localparam int MDC_DIV_W = $clog2(MDC_HALF_DIV);

	// Clause 22 preamble, all ones
	localparam int MDIO_PREAMBLE_LEN = 32;

	// Microwire start bit plus 2-bit opcode
	typedef enum logic [2:0] {
		EE_OP_EXT   = 3'b100,
		EE_OP_WRITE = 3'b101,
		EE_OP_READ  = 3'b110,
		EE_OP_ERASE = 3'b111
	} ee_op_e;

	// Clause 22 opcodes
	typedef enum logic [1:0] {
		MDIO_WR = 2'b01,
		MDIO_RD = 2'b10
	} mdio_op_e;

	typedef enum logic [2:0] {
		EE_IDLE,
		EE_CMD,
		EE_ADDR,
		EE_DATA,
		EE_DONE
	} ee_state_e;

	typedef enum logic [2:0] {
		MD_IDLE,
		MD_PRE,
		MD_HDR,
		MD_TA,
		MD_DATA,
		MD_DONE
	} mdio_state_e;

endpackage

// File: regs/e1000_regs.sv
`timescale 1ns/1ns

module e1000_regs
	import e1000_reg_pkg::*;
	import e1000_serial_pkg::*;
(
	input  logic        aclk,
	input  logic        arst_n_i,

	// AXI-Lite write
	input  logic [31:0] s_awaddr_i,
	input  logic        s_awvalid_i,
	output logic        s_awready_o,
	input  logic [31:0] s_wdata_i,
	input  logic [3:0]  s_wstrb_i,
	input  logic        s_wvalid_i,
	output logic        s_wready_o,
	output logic [1:0]  s_bresp_o,
	output logic        s_bvalid_o,
	input  logic        s_bready_i,

	// AXI-Lite read
	input  logic [31:0] s_araddr_i,
	input  logic        s_arvalid_i,
	output logic        s_arready_o,
	output logic [31:0] s_rdata_o,
	output logic [1:0]  s_rresp_o,
	output logic        s_rvalid_o,
	input  logic        s_rready_i,

	// EEPROM shifter
	output logic        ee_start_o,
	output logic [5:0]  ee_addr_o,
	input  logic        ee_busy_i,
	input  logic        ee_done_i,
	input  logic [15:0] ee_rdata_i,
	output logic        bb_req_o,
	output logic        bb_sk_o,
	output logic        bb_cs_o,
	output logic        bb_di_o,
	input  logic        bb_gnt_i,
	input  logic        bb_do_i,

	// MDIO shifter
	output logic        md_start_o,
	output mdio_op_e    md_op_o,
	output logic [4:0]  md_phy_o,
	output logic [4:0]  md_reg_o,
	output logic [15:0] md_wdata_o,
	input  logic        md_done_i,
	input  logic [15:0] md_rdata_i,
	input  logic        md_err_i
);

// Handshake state
logic wr_acc_q;
logic ar_acc_q;
logic bvalid_q;
logic rvalid_q;
logic [31:0] rdata_q;

// Word-aligned decode
logic [31:0] wr_addr;
logic [31:0] rd_addr;
logic wr_eecd;
logic wr_eerd;
logic wr_mdic;
logic [31:0] rd_word;

// EECD
logic eecd_sk_q;
logic eecd_cs_q;
logic eecd_di_q;
logic eecd_req_q;

// EERD
logic eerd_done_q;
logic [5:0] eerd_addr_q;
logic [15:0] eerd_data_q;
logic ee_start_q;

// MDIC
logic [1:0] mdic_op_q;
logic [4:0] mdic_phy_q;
logic [4:0] mdic_reg_q;
logic [15:0] mdic_data_q;
logic mdic_r_q;
logic mdic_e_q;
logic md_start_q;

assign wr_addr = {s_awaddr_i[31:2], 2'b00};
assign rd_addr = {s_araddr_i[31:2], 2'b00};

// Register write happens in the ready cycle
assign wr_eecd = wr_acc_q && (wr_addr == REG_EECD);
assign wr_eerd = wr_acc_q && (wr_addr == REG_EERD);
assign wr_mdic = wr_acc_q && (wr_addr == REG_MDIC);

// Read mux, unmapped reads as zero
always_comb begin
	rd_word = '0;
	case (rd_addr)
		REG_EECD: begin
			rd_word[EECD_SK] = eecd_sk_q;
			rd_word[EECD_CS] = eecd_cs_q;
			rd_word[EECD_DI] = eecd_di_q;
			rd_word[EECD_DO] = bb_do_i;
			rd_word[EECD_REQ] = eecd_req_q;
			rd_word[EECD_GNT] = bb_gnt_i;
		end
		REG_EERD: begin
			rd_word[EERD_DONE] = eerd_done_q;
			rd_word[EERD_ADDR_LO +: 6] = eerd_addr_q;
			rd_word[EERD_DATA_LO +: 16] = eerd_data_q;
		end
		REG_MDIC: begin
			rd_word[MDIC_DATA_LO +: 16] = mdic_data_q;
			rd_word[MDIC_REG_LO +: 5] = mdic_reg_q;
			rd_word[MDIC_PHY_LO +: 5] = mdic_phy_q;
			rd_word[MDIC_OP_LO +: 2] = mdic_op_q;
			rd_word[MDIC_R] = mdic_r_q;
			rd_word[MDIC_E] = mdic_e_q;
		end
		default: rd_word = '0;
	endcase
end

// AXI-Lite channel handshakes
always_ff @(posedge aclk or negedge arst_n_i) begin
	if (!arst_n_i) begin
		wr_acc_q <= 1'b0;
		bvalid_q <= 1'b0;
		ar_acc_q <= 1'b0;
		rvalid_q <= 1'b0;
	end else begin
		// Address and data taken together, one beat per response
		wr_acc_q <= s_awvalid_i && s_wvalid_i && !bvalid_q && !wr_acc_q;
		if (wr_acc_q)
			bvalid_q <= 1'b1;
		else if (s_bready_i)
			bvalid_q <= 1'b0;

		ar_acc_q <= s_arvalid_i && !rvalid_q && !ar_acc_q;
		if (ar_acc_q)
			rvalid_q <= 1'b1;
		else if (s_rready_i)
			rvalid_q <= 1'b0;
	end
end

// Read data captured with arready
always_ff @(posedge aclk) begin
	if (ar_acc_q)
		rdata_q <= rd_word;
end

// Register contents and shifter handoff
always_ff @(posedge aclk or negedge arst_n_i) begin
	if (!arst_n_i) begin
		eecd_sk_q <= 1'b0;
		eecd_cs_q <= 1'b0;
		eecd_di_q <= 1'b0;
		eecd_req_q <= 1'b0;
		eerd_done_q <= 1'b0;
		eerd_addr_q <= '0;
		eerd_data_q <= '0;
		ee_start_q <= 1'b0;
		mdic_op_q <= '0;
		mdic_phy_q <= '0;
		mdic_reg_q <= '0;
		mdic_data_q <= '0;
		mdic_r_q <= 1'b1;
		mdic_e_q <= 1'b0;
		md_start_q <= 1'b0;
	end else begin
		ee_start_q <= 1'b0;
		md_start_q <= 1'b0;

		// Pin bits all live in byte 0
		if (wr_eecd && s_wstrb_i[0]) begin
			eecd_sk_q <= s_wdata_i[EECD_SK];
			eecd_cs_q <= s_wdata_i[EECD_CS];
			eecd_di_q <= s_wdata_i[EECD_DI];
			eecd_req_q <= s_wdata_i[EECD_REQ];
		end

		// DONE drops on any START, engine only launched when free
		if (wr_eerd && s_wdata_i[EERD_START]) begin
			eerd_done_q <= 1'b0;
			if (!ee_busy_i && !eecd_req_q) begin
				eerd_addr_q <= s_wdata_i[EERD_ADDR_LO +: 6];
				ee_start_q <= 1'b1;
			end
		end
		if (ee_done_i) begin
			eerd_done_q <= 1'b1;
			eerd_data_q <= ee_rdata_i;
		end

		// MDIC writes while busy are dropped
		if (wr_mdic && mdic_r_q) begin
			mdic_data_q <= s_wdata_i[MDIC_DATA_LO +: 16];
			mdic_reg_q <= s_wdata_i[MDIC_REG_LO +: 5];
			mdic_phy_q <= s_wdata_i[MDIC_PHY_LO +: 5];
			mdic_op_q <= s_wdata_i[MDIC_OP_LO +: 2];
			mdic_r_q <= 1'b0;
			mdic_e_q <= 1'b0;
			md_start_q <= 1'b1;
		end
		if (md_done_i) begin
			mdic_r_q <= 1'b1;
			mdic_e_q <= md_err_i;
			// Write data stays visible after a write cycle
			if (mdic_op_q == MDIO_RD)
				mdic_data_q <= md_rdata_i;
		end
	end
end

assign s_awready_o = wr_acc_q;
assign s_wready_o = wr_acc_q;
assign s_bvalid_o = bvalid_q;
assign s_bresp_o = AXI_OKAY;
assign s_arready_o = ar_acc_q;
assign s_rvalid_o = rvalid_q;
assign s_rdata_o = rdata_q;
assign s_rresp_o = AXI_OKAY;

assign ee_start_o = ee_start_q;
assign ee_addr_o = eerd_addr_q;
assign bb_req_o = eecd_req_q;
assign bb_sk_o = eecd_sk_q;
assign bb_cs_o = eecd_cs_q;
assign bb_di_o = eecd_di_q;

assign md_start_o = md_start_q;
assign md_op_o = mdio_op_e'(mdic_op_q);
assign md_phy_o = mdic_phy_q;
assign md_reg_o = mdic_reg_q;
assign md_wdata_o = mdic_data_q;

// Responses held until the master takes them
a_bvalid_hold: assert property (@(posedge aclk) disable iff (!arst_n_i)
	s_bvalid_o && !s_bready_i |=> s_bvalid_o);
a_rvalid_hold: assert property (@(posedge aclk) disable iff (!arst_n_i)
	s_rvalid_o && !s_rready_i |=> s_rvalid_o && $stable(s_rdata_o));

endmodule

// File: verilog/eeprom_shifter.sv
`timescale 1ns/1ns

module eeprom_shifter
	import e1000_serial_pkg::*;
(
	input  logic        aclk,
	input  logic        arst_n_i,

	// From the register block
	input  logic        start_i,
	input  logic [5:0]  addr_i,
	input  logic        bb_req_i,
	input  logic        bb_sk_i,
	input  logic        bb_cs_i,
	input  logic        bb_di_i,

	// To the register block
	output logic        busy_o,
	output logic        done_o,
	output logic [15:0] rdata_o,
	output logic        bb_gnt_o,

	// Microwire pins
	output logic        ee_sk_o,
	output logic        ee_cs_o,
	output logic        ee_di_o,
	input  logic        ee_do_i
);

ee_state_e state_q;
logic [EE_DIV_W-1:0] div_q;
logic tick;
logic [3:0] bit_q;
logic [8:0] cmd_word;
logic [8:0] sr_q;
logic [15:0] rdata_q;
logic sk_q;
logic cs_q;
logic di_q;
logic gnt_q;

// Start bit and opcode, then word address
assign cmd_word = {EE_OP_READ, addr_i};

// Half SK period strobe
assign tick = (div_q == EE_DIV_W'(EE_HALF_DIV - 1));

always_ff @(posedge aclk or negedge arst_n_i) begin
	if (!arst_n_i) begin
		state_q <= EE_IDLE;
		div_q <= '0;
		bit_q <= '0;
		sk_q <= 1'b0;
		cs_q <= 1'b0;
		di_q <= 1'b0;
		gnt_q <= 1'b0;
	end else begin
		div_q <= (tick || state_q == EE_IDLE) ? '0 : div_q + 1'b1;
		case (state_q)
			EE_IDLE: begin
				// Pins handed to software only while idle
				gnt_q <= bb_req_i;
				if (start_i && !bb_req_i) begin
					state_q <= EE_CMD;
					cs_q <= 1'b1;
					sk_q <= 1'b0;
					di_q <= cmd_word[8];
					bit_q <= 4'd2;
				end
			end
			EE_DONE: begin
				state_q <= EE_IDLE;
			end
			default: begin
				if (tick) begin
					sk_q <= !sk_q;
					// Falling SK edge moves to the next bit
					if (sk_q) begin
						di_q <= sr_q[7];
						bit_q <= bit_q - 1'b1;
						if (bit_q == 4'd0) begin
							case (state_q)
								EE_CMD: begin
									state_q <= EE_ADDR;
									bit_q <= 4'd5;
								end
								EE_ADDR: begin
									state_q <= EE_DATA;
									bit_q <= 4'd15;
									di_q <= 1'b0;
								end
								default: begin
									// Last data bit taken, end of cycle
									state_q <= EE_DONE;
									cs_q <= 1'b0;
								end
							endcase
						end
					end
				end
			end
		endcase
	end
end

// Command shift register, follows the address while idle
always_ff @(posedge aclk) begin
	if (state_q == EE_IDLE)
		sr_q <= cmd_word;
	else if (tick && sk_q)
		sr_q <= {sr_q[7:0], 1'b0};
end

// DO sampled MSB first on the rising SK edge
always_ff @(posedge aclk) begin
	if (tick && !sk_q && state_q == EE_DATA)
		rdata_q <= {rdata_q[14:0], ee_do_i};
end

assign busy_o = (state_q != EE_IDLE);
assign done_o = (state_q == EE_DONE);
assign rdata_o = rdata_q;
assign bb_gnt_o = gnt_q;

// EECD pin override under grant
assign ee_sk_o = gnt_q ? bb_sk_i : sk_q;
assign ee_cs_o = gnt_q ? bb_cs_i : cs_q;
assign ee_di_o = gnt_q ? bb_di_i : di_q;

// Chip stays deselected between hardware reads unless software owns it
a_cs_idle: assert property (@(posedge aclk) disable iff (!arst_n_i)
	(state_q == EE_IDLE && !bb_gnt_o) |-> !ee_cs_o);

endmodule

// File: verilog/mdio_shifter.sv
`timescale 1ns/1ns

module mdio_shifter
	import e1000_serial_pkg::*;
(
	input  logic        aclk,
	input  logic        arst_n_i,

	// From the register block
	input  logic        start_i,
	input  mdio_op_e    op_i,
	input  logic [4:0]  phy_i,
	input  logic [4:0]  reg_i,
	input  logic [15:0] wdata_i,

	// To the register block
	output logic        done_o,
	output logic [15:0] rdata_o,
	output logic        err_o,

	// PHY management pins
	output logic        mdc_o,
	input  logic        mdio_i,
	output logic        mdio_o,
	output logic        mdio_oe_o
);

mdio_state_e state_q;
mdio_op_e op_q;
logic [MDC_DIV_W-1:0] div_q;
logic tick;
logic is_rd;
logic [4:0] bit_q;
logic [31:0] frame;
logic [31:0] sr_q;
logic [15:0] rdata_q;
logic mdc_q;
logic mdo_q;
logic oe_q;
logic err_q;

// Frame after preamble: ST, OP, PHYAD, REGAD, TA, DATA
assign frame = {2'b01, op_i, phy_i, reg_i, 2'b10, wdata_i};
assign is_rd = (op_q == MDIO_RD);

// Half MDC period strobe
assign tick = (div_q == MDC_DIV_W'(MDC_HALF_DIV - 1));

always_ff @(posedge aclk or negedge arst_n_i) begin
	if (!arst_n_i) begin
		state_q <= MD_IDLE;
		op_q <= MDIO_RD;
		div_q <= '0;
		bit_q <= '0;
		mdc_q <= 1'b0;
		mdo_q <= 1'b1;
		oe_q <= 1'b0;
		err_q <= 1'b0;
	end else begin
		div_q <= (tick || state_q == MD_IDLE) ? '0 : div_q + 1'b1;
		case (state_q)
			MD_IDLE: begin
				if (start_i) begin
					state_q <= MD_PRE;
					op_q <= op_i;
					mdc_q <= 1'b0;
					mdo_q <= 1'b1;
					oe_q <= 1'b1;
					err_q <= 1'b0;
					bit_q <= 5'(MDIO_PREAMBLE_LEN - 1);
				end
			end
			MD_DONE: begin
				state_q <= MD_IDLE;
			end
			default: begin
				if (tick) begin
					mdc_q <= !mdc_q;
					if (!mdc_q) begin
						// Rising MDC, PHY must pull second TA bit low
						if (state_q == MD_TA && bit_q == 5'd0 && is_rd)
							err_q <= mdio_i;
					end else begin
						// Falling MDC, next bit onto the line
						mdo_q <= sr_q[31];
						bit_q <= bit_q - 1'b1;
						case (state_q)
							MD_PRE: begin
								if (bit_q == 5'd0) begin
									state_q <= MD_HDR;
									bit_q <= 5'd13;
								end else begin
									mdo_q <= 1'b1;
								end
							end
							MD_HDR: begin
								if (bit_q == 5'd0) begin
									state_q <= MD_TA;
									bit_q <= 5'd1;
									// Line released for the PHY on reads
									oe_q <= !is_rd;
								end
							end
							MD_TA: begin
								if (bit_q == 5'd0) begin
									state_q <= MD_DATA;
									bit_q <= 5'd15;
								end
							end
							default: begin
								if (bit_q == 5'd0) begin
									state_q <= MD_DONE;
									oe_q <= 1'b0;
								end
							end
						endcase
					end
				end
			end
		endcase
	end
end

// Frame shifter, preamble bits come from the constant above
always_ff @(posedge aclk) begin
	if (state_q == MD_IDLE)
		sr_q <= frame;
	else if (tick && mdc_q && (state_q != MD_PRE || bit_q == 5'd0))
		sr_q <= {sr_q[30:0], 1'b0};
end

// Read data, MSB first on rising MDC
always_ff @(posedge aclk) begin
	if (tick && !mdc_q && state_q == MD_DATA && is_rd)
		rdata_q <= {rdata_q[14:0], mdio_i};
end

assign done_o = (state_q == MD_DONE);
assign rdata_o = rdata_q;
assign err_o = err_q;
assign mdc_o = mdc_q;
assign mdio_o = mdo_q;
assign mdio_oe_o = oe_q;

// No bus fight with the PHY while it returns data
a_rd_released: assert property (@(posedge aclk) disable iff (!arst_n_i)
	(state_q == MD_DATA && op_q == MDIO_RD) |-> !mdio_oe_o);

endmodule

// File: verilog/e1000_mgmt_top.sv
`timescale 1ns/1ns

module e1000_mgmt_top
	import e1000_serial_pkg::*;
(
	input  logic        aclk,
	input  logic        arst_n_i,

	// Register port
	input  logic [31:0] s_awaddr_i,
	input  logic        s_awvalid_i,
	output logic        s_awready_o,
	input  logic [31:0] s_wdata_i,
	input  logic [3:0]  s_wstrb_i,
	input  logic        s_wvalid_i,
	output logic        s_wready_o,
	output logic [1:0]  s_bresp_o,
	output logic        s_bvalid_o,
	input  logic        s_bready_i,
	input  logic [31:0] s_araddr_i,
	input  logic        s_arvalid_i,
	output logic        s_arready_o,
	output logic [31:0] s_rdata_o,
	output logic [1:0]  s_rresp_o,
	output logic        s_rvalid_o,
	input  logic        s_rready_i,

	// EEPROM pins
	output logic        ee_sk_o,
	output logic        ee_cs_o,
	output logic        ee_di_o,
	input  logic        ee_do_i,

	// PHY pins
	output logic        mdc_o,
	input  logic        mdio_i,
	output logic        mdio_o,
	output logic        mdio_oe_o,
	output logic        phy_reset_o
);

// Register block to EEPROM engine
logic ee_start;
logic [5:0] ee_addr;
logic ee_busy;
logic ee_done;
logic [15:0] ee_rdata;
logic bb_req;
logic bb_sk;
logic bb_cs;
logic bb_di;
logic bb_gnt;

// Register block to MDIO engine
logic md_start;
mdio_op_e md_op;
logic [4:0] md_phy;
logic [4:0] md_reg;
logic [15:0] md_wdata;
logic md_done;
logic [15:0] md_rdata;
logic md_err;

// PHY held in reset with the system
assign phy_reset_o = !arst_n_i;

// AXI ports match by name
e1000_regs u_regs (
	.*,
	.ee_start_o(ee_start),
	.ee_addr_o(ee_addr),
	.ee_busy_i(ee_busy),
	.ee_done_i(ee_done),
	.ee_rdata_i(ee_rdata),
	.bb_req_o(bb_req),
	.bb_sk_o(bb_sk),
	.bb_cs_o(bb_cs),
	.bb_di_o(bb_di),
	.bb_gnt_i(bb_gnt),
	.bb_do_i(ee_do_i),
	.md_start_o(md_start),
	.md_op_o(md_op),
	.md_phy_o(md_phy),
	.md_reg_o(md_reg),
	.md_wdata_o(md_wdata),
	.md_done_i(md_done),
	.md_rdata_i(md_rdata),
	.md_err_i(md_err)
);

eeprom_shifter u_eeprom (
	.*,
	.start_i(ee_start),
	.addr_i(ee_addr),
	.bb_req_i(bb_req),
	.bb_sk_i(bb_sk),
	.bb_cs_i(bb_cs),
	.bb_di_i(bb_di),
	.busy_o(ee_busy),
	.done_o(ee_done),
	.rdata_o(ee_rdata),
	.bb_gnt_o(bb_gnt)
);

mdio_shifter u_mdio (
	.*,
	.start_i(md_start),
	.op_i(md_op),
	.phy_i(md_phy),
	.reg_i(md_reg),
	.wdata_i(md_wdata),
	.done_o(md_done),
	.rdata_o(md_rdata),
	.err_o(md_err)
);

endmodule

// File: bench/tb_clkgen.sv
`timescale 1ns/1ns

module tb_clkgen #(
	parameter int HALF_PERIOD = 5,
	parameter int RST_CYCLES = 8
) (
	output logic clk_o,
	output logic rst_n_o
);

// 10 ns free-running clock
initial begin
	clk_o = 1'b0;
	forever #(HALF_PERIOD) clk_o = !clk_o;
end

// Reset held low for a fixed number of edges, released off the edge
initial begin
	rst_n_o = 1'b0;
	repeat (RST_CYCLES) @(posedge clk_o);
	#1 rst_n_o = 1'b1;
end

endmodule

// File: bench/phy_eeprom_model.sv
`timescale 1ns/1ns

module phy_eeprom_model (
	// Microwire side
	input  logic ee_sk_i,
	input  logic ee_cs_i,
	input  logic ee_di_i,
	output logic ee_do_o,

	// MDIO side
	input  logic mdc_i,
	input  logic mdio_drv_i,
	input  logic mdio_oe_i,
	output logic mdio_o
);

localparam logic [4:0] PHY_ADDR = 5'd1;

// 93C46 contents, loaded by the testbench
logic [15:0] ee_mem [64];
logic [3:0] cmd_cnt = '0;
logic [8:0] cmd_sr = '0;
logic [8:0] cmd_full;
logic [15:0] out_sr = '0;
logic reading = 1'b0;

// PHY register file
logic [15:0] phy_regs [32];
typedef enum logic [2:0] {P_HUNT, P_ST1, P_HDR, P_TA, P_DATA} phy_ph_e;
phy_ph_e ph = P_HUNT;
int ones = 0;
int cnt = 0;
logic [10:0] hdr_sr = '0;
logic [11:0] hdr_full;
logic [1:0] op_q = '0;
logic [4:0] phy_q = '0;
logic [4:0] reg_q = '0;
logic [15:0] dsr = '0;
logic phy_oe = 1'b0;
logic phy_drv = 1'b1;
logic line;

initial begin
	ee_do_o = 1'b0;
	for (int i = 0; i < 32; i++)
		phy_regs[i] = '0;
end

assign cmd_full = {cmd_sr[7:0], ee_di_i};

// Command in on rising SK, data out after the last address bit
always @(posedge ee_sk_i or negedge ee_cs_i) begin
	if (!ee_cs_i) begin
		cmd_cnt <= '0;
		cmd_sr <= '0;
		reading <= 1'b0;
		ee_do_o <= 1'b0;
	end else if (reading) begin
		// Next bit after the host took this one
		ee_do_o <= out_sr[14];
		out_sr <= {out_sr[14:0], 1'b0};
	end else begin
		cmd_sr <= cmd_full;
		cmd_cnt <= cmd_cnt + 4'd1;
		// Start bit 1, READ opcode 10
		if (cmd_cnt == 4'd8 && cmd_full[8:6] == 3'b110) begin
			reading <= 1'b1;
			out_sr <= ee_mem[cmd_full[5:0]];
			ee_do_o <= ee_mem[cmd_full[5:0]][15];
		end
	end
end

// Shared line with pull-up
assign line = mdio_oe_i ? mdio_drv_i : (phy_oe ? phy_drv : 1'b1);
assign mdio_o = line;
assign hdr_full = {hdr_sr, line};

// Clause 22 frame decode, all sampling on rising MDC
always @(posedge mdc_i) begin
	case (ph)
		P_HUNT: begin
			if (line) begin
				ones <= ones + 1;
			end else begin
				if (ones >= 32)
					ph <= P_ST1;
				ones <= 0;
			end
		end
		P_ST1: begin
			ph <= line ? P_HDR : P_HUNT;
			cnt <= 0;
		end
		P_HDR: begin
			hdr_sr <= hdr_full[10:0];
			cnt <= cnt + 1;
			// OP, PHYAD, REGAD complete
			if (cnt == 11) begin
				op_q <= hdr_full[11:10];
				phy_q <= hdr_full[9:5];
				reg_q <= hdr_full[4:0];
				ph <= P_TA;
				cnt <= 0;
			end
		end
		P_TA: begin
			cnt <= cnt + 1;
			if (op_q == 2'b10 && phy_q == PHY_ADDR) begin
				// Second TA bit driven low, then data MSB
				phy_oe <= 1'b1;
				phy_drv <= (cnt == 0) ? 1'b0 : phy_regs[reg_q][15];
				dsr <= phy_regs[reg_q];
			end
			if (cnt == 1) begin
				ph <= P_DATA;
				cnt <= 0;
			end
		end
		default: begin
			cnt <= cnt + 1;
			if (op_q == 2'b10) begin
				phy_drv <= dsr[14];
				dsr <= {dsr[14:0], 1'b0};
			end else begin
				dsr <= {dsr[14:0], line};
			end
			if (cnt == 15) begin
				if (op_q == 2'b01 && phy_q == PHY_ADDR)
					phy_regs[reg_q] <= {dsr[14:0], line};
				phy_oe <= 1'b0;
				phy_drv <= 1'b1;
				ones <= 0;
				ph <= P_HUNT;
			end
		end
	endcase
end

endmodule

// File: bench/tb_e1000_mgmt.sv
`timescale 1ns/1ns

module tb_e1000_mgmt
	import e1000_reg_pkg::*;
	import e1000_serial_pkg::*;
;

localparam int TMO = 400;
localparam int WATCHDOG_NS = 5_000_000;

logic aclk;
logic arst_n;
logic [31:0] s_awaddr_i;
logic s_awvalid_i;
logic s_awready_o;
logic [31:0] s_wdata_i;
logic [3:0] s_wstrb_i;
logic s_wvalid_i;
logic s_wready_o;
logic [1:0] s_bresp_o;
logic s_bvalid_o;
logic s_bready_i;
logic [31:0] s_araddr_i;
logic s_arvalid_i;
logic s_arready_o;
logic [31:0] s_rdata_o;
logic [1:0] s_rresp_o;
logic s_rvalid_o;
logic s_rready_i;
logic ee_sk;
logic ee_cs;
logic ee_di;
logic ee_do;
logic mdc;
logic mdio_in;
logic mdio_out;
logic mdio_oe;
logic phy_reset;

// Reference contents
logic [15:0] ee_ref [64];
logic [15:0] phy_ref [32];

string test_name;
int test_errs;
int total_errs;
int tests_run;
int tests_failed;

tb_clkgen u_clk (
	.clk_o(aclk),
	.rst_n_o(arst_n)
);

e1000_mgmt_top dut (
	.aclk(aclk),
	.arst_n_i(arst_n),
	.s_awaddr_i(s_awaddr_i),
	.s_awvalid_i(s_awvalid_i),
	.s_awready_o(s_awready_o),
	.s_wdata_i(s_wdata_i),
	.s_wstrb_i(s_wstrb_i),
	.s_wvalid_i(s_wvalid_i),
	.s_wready_o(s_wready_o),
	.s_bresp_o(s_bresp_o),
	.s_bvalid_o(s_bvalid_o),
	.s_bready_i(s_bready_i),
	.s_araddr_i(s_araddr_i),
	.s_arvalid_i(s_arvalid_i),
	.s_arready_o(s_arready_o),
	.s_rdata_o(s_rdata_o),
	.s_rresp_o(s_rresp_o),
	.s_rvalid_o(s_rvalid_o),
	.s_rready_i(s_rready_i),
	.ee_sk_o(ee_sk),
	.ee_cs_o(ee_cs),
	.ee_di_o(ee_di),
	.ee_do_i(ee_do),
	.mdc_o(mdc),
	.mdio_i(mdio_in),
	.mdio_o(mdio_out),
	.mdio_oe_o(mdio_oe),
	.phy_reset_o(phy_reset)
);

phy_eeprom_model u_model (
	.ee_sk_i(ee_sk),
	.ee_cs_i(ee_cs),
	.ee_di_i(ee_di),
	.ee_do_o(ee_do),
	.mdc_i(mdc),
	.mdio_drv_i(mdio_out),
	.mdio_oe_i(mdio_oe),
	.mdio_o(mdio_in)
);

task automatic report_mismatch(input string what, input logic [31:0] exp,
		input logic [31:0] act);
	$display("ERR %s %s expected %h actual %h", test_name, what, exp, act);
	test_errs++;
endtask

task automatic report_fail(input string msg);
	$display("%s: %s", test_name, msg);
	test_errs++;
endtask

task automatic start_test(input string name);
	test_name = name;
	test_errs = 0;
endtask

task automatic finish_test();
	tests_run++;
	total_errs += test_errs;
	if (test_errs != 0)
		tests_failed++;
	$display("test %s: %s (%0d errors)", test_name, (test_errs == 0) ? "ok" : "FAILED",
		test_errs);
endtask

// Random back-pressure before bready/rready
task automatic idle_cycles(input int max_n);
	int n;
	n = $urandom % max_n;
	repeat (n) begin
		@(posedge aclk);
		#1;
	end
endtask

task automatic axi_write(input logic [31:0] addr, input logic [31:0] data,
		input logic [3:0] strb);
	int n;
	logic done;
	s_awaddr_i = addr;
	s_wdata_i = data;
	s_wstrb_i = strb;
	s_awvalid_i = 1'b1;
	s_wvalid_i = 1'b1;
	n = 0;
	done = 1'b0;
	while (!done && n < TMO) begin
		@(posedge aclk);
		#1;
		n++;
		if (s_awready_o && s_wready_o)
			done = 1'b1;
	end
	if (!done)
		report_fail("write address and data never accepted");
	// Handshake completes on this edge
	@(posedge aclk);
	#1;
	s_awvalid_i = 1'b0;
	s_wvalid_i = 1'b0;
	idle_cycles(4);
	s_bready_i = 1'b1;
	n = 0;
	done = 1'b0;
	while (!done && n < TMO) begin
		if (s_bvalid_o) begin
			done = 1'b1;
		end else begin
			@(posedge aclk);
			#1;
			n++;
		end
	end
	if (!done)
		report_fail("write response never arrived");
	else if (s_bresp_o !== AXI_OKAY)
		report_mismatch("bresp", {30'h0, AXI_OKAY}, {30'h0, s_bresp_o});
	@(posedge aclk);
	#1;
	s_bready_i = 1'b0;
endtask

task automatic axi_read(input logic [31:0] addr, output logic [31:0] data);
	int n;
	logic done;
	data = '0;
	s_araddr_i = addr;
	s_arvalid_i = 1'b1;
	n = 0;
	done = 1'b0;
	while (!done && n < TMO) begin
		@(posedge aclk);
		#1;
		n++;
		if (s_arready_o)
			done = 1'b1;
	end
	if (!done)
		report_fail("read address never accepted");
	@(posedge aclk);
	#1;
	s_arvalid_i = 1'b0;
	idle_cycles(4);
	s_rready_i = 1'b1;
	n = 0;
	done = 1'b0;
	while (!done && n < TMO) begin
		if (s_rvalid_o) begin
			done = 1'b1;
			data = s_rdata_o;
		end else begin
			@(posedge aclk);
			#1;
			n++;
		end
	end
	if (!done)
		report_fail("read data never arrived");
	else if (s_rresp_o !== AXI_OKAY)
		report_mismatch("rresp", {30'h0, AXI_OKAY}, {30'h0, s_rresp_o});
	@(posedge aclk);
	#1;
	s_rready_i = 1'b0;
endtask

// Poll until a status bit is set
task automatic poll_bit(input logic [31:0] addr, input int bit_pos,
		output logic [31:0] v);
	int n;
	n = 0;
	axi_read(addr, v);
	while (!v[bit_pos] && n < TMO) begin
		axi_read(addr, v);
		n++;
	end
	if (!v[bit_pos])
		report_fail("status bit never set while polling");
endtask

task automatic ee_read(input logic [5:0] a, output logic [31:0] v);
	logic [31:0] w;
	w = '0;
	w[EERD_START] = 1'b1;
	w[EERD_ADDR_LO +: 6] = a;
	axi_write(REG_EERD, w, 4'hF);
	poll_bit(REG_EERD, EERD_DONE, v);
endtask

task automatic mdio_cycle(input logic [1:0] op, input logic [4:0] phy, input logic [4:0] rg,
		input logic [15:0] d, output logic [31:0] v);
	logic [31:0] w;
	w = '0;
	w[MDIC_DATA_LO +: 16] = d;
	w[MDIC_REG_LO +: 5] = rg;
	w[MDIC_PHY_LO +: 5] = phy;
	w[MDIC_OP_LO +: 2] = op;
	axi_write(REG_MDIC, w, 4'hF);
	poll_bit(REG_MDIC, MDIC_R, v);
endtask

// Software-owned Microwire pins
task automatic bb_pins(input logic cs, input logic sk, input logic di);
	logic [31:0] w;
	w = '0;
	w[EECD_REQ] = 1'b1;
	w[EECD_CS] = cs;
	w[EECD_SK] = sk;
	w[EECD_DI] = di;
	axi_write(REG_EECD, w, 4'hF);
endtask

// Runaway guard
initial begin
	#(WATCHDOG_NS);
	$display("watchdog expired before the tests finished");
	$display("Simulation failed");
	$finish;
end

initial begin
	logic [31:0] r;
	logic [31:0] v;
	logic [31:0] w;
	logic [31:0] exp;
	logic [5:0] a;
	logic [4:0] rg;
	logic [15:0] d;
	logic [15:0] word;
	logic [8:0] cmd;
	logic [2:0] eecd_sh;
	int n;

	s_awaddr_i = '0;
	s_awvalid_i = 1'b0;
	s_wdata_i = '0;
	s_wstrb_i = '0;
	s_wvalid_i = 1'b0;
	s_bready_i = 1'b0;
	s_araddr_i = '0;
	s_arvalid_i = 1'b0;
	s_rready_i = 1'b0;
	total_errs = 0;
	tests_run = 0;
	tests_failed = 0;
	test_name = "setup";
	test_errs = 0;

	r = $urandom(91267);
	for (int i = 0; i < 64; i++) begin
		r = $urandom;
		ee_ref[i] = r[15:0];
		u_model.ee_mem[i] = r[15:0];
	end
	for (int i = 0; i < 32; i++)
		phy_ref[i] = '0;

	// 1: reset values
	start_test("reset");
	// PHY held in reset along with the system
	@(posedge aclk);
	#1;
	if (phy_reset !== 1'b1)
		report_mismatch("phy_reset in reset", 32'h1, {31'h0, phy_reset});
	n = 0;
	while (!arst_n && n < 100) begin
		@(posedge aclk);
		n++;
	end
	if (!arst_n)
		report_fail("reset never released");
	@(posedge aclk);
	#1;
	if (phy_reset !== 1'b0)
		report_mismatch("phy_reset", 32'h0, {31'h0, phy_reset});
	axi_read(REG_EECD, v);
	if (v[EECD_GNT] !== 1'b0)
		report_mismatch("EECD.GNT", 32'h0, {31'h0, v[EECD_GNT]});
	axi_read(REG_EERD, v);
	if (v[EERD_DONE] !== 1'b0)
		report_mismatch("EERD.DONE", 32'h0, {31'h0, v[EERD_DONE]});
	axi_read(REG_MDIC, v);
	if (v[MDIC_R] !== 1'b1 || v[MDIC_E] !== 1'b0)
		report_mismatch("MDIC.R/E", 32'h1, {30'h0, v[MDIC_E], v[MDIC_R]});
	finish_test();

	// 2: hardware EEPROM reads
	start_test("eerd_random");
	for (int i = 0; i < 8; i++) begin
		r = $urandom;
		a = r[5:0];
		ee_read(a, v);
		if (v[EERD_DATA_LO +: 16] !== ee_ref[a])
			report_mismatch("EERD.DATA", {16'h0, ee_ref[a]}, {16'h0, v[EERD_DATA_LO +: 16]});
		if (v[EERD_ADDR_LO +: 6] !== a)
			report_mismatch("EERD.ADDR", {26'h0, a}, {26'h0, v[EERD_ADDR_LO +: 6]});
	end
	finish_test();

	// 3: PHY 1 write then read back
	start_test("mdio_wr_rd");
	for (int i = 0; i < 6; i++) begin
		r = $urandom;
		rg = r[20:16];
		d = r[15:0];
		mdio_cycle(MDIO_WR, 5'd1, rg, d, v);
		if (v[MDIC_E] !== 1'b0)
			report_fail("MDIC.E set after write");
		phy_ref[rg] = d;
		mdio_cycle(MDIO_RD, 5'd1, rg, 16'h0, v);
		if (v[MDIC_DATA_LO +: 16] !== phy_ref[rg])
			report_mismatch("MDIC.DATA", {16'h0, phy_ref[rg]}, {16'h0, v[15:0]});
		if (v[MDIC_E] !== 1'b0 || v[MDIC_R] !== 1'b1)
			report_mismatch("MDIC.R/E", 32'h1, {30'h0, v[MDIC_E], v[MDIC_R]});
	end
	finish_test();

	// 4: absent PHY, line stays pulled up
	start_test("mdio_no_phy");
	mdio_cycle(MDIO_RD, 5'd5, 5'd2, 16'h0, v);
	if (v[MDIC_E] !== 1'b1)
		report_mismatch("MDIC.E", 32'h1, {31'h0, v[MDIC_E]});
	if (v[MDIC_DATA_LO +: 16] !== 16'hFFFF)
		report_mismatch("MDIC.DATA", 32'hFFFF, {16'h0, v[15:0]});
	finish_test();

	// 5: EECD bit-bang
	start_test("eecd_bitbang");
	bb_pins(1'b0, 1'b0, 1'b0);
	axi_read(REG_EECD, v);
	if (v[EECD_GNT] !== 1'b1)
		report_mismatch("EECD.GNT", 32'h1, {31'h0, v[EECD_GNT]});
	w = '0;
	w[EERD_START] = 1'b1;
	axi_write(REG_EERD, w, 4'hF);
	repeat (300) @(posedge aclk);
	#1;
	axi_read(REG_EERD, v);
	if (v[EERD_DONE] !== 1'b0)
		report_fail("EERD finished while software owned the pins");
	r = $urandom;
	a = r[5:0];
	cmd = {3'b110, a};
	bb_pins(1'b1, 1'b0, 1'b0);
	for (int b = 8; b >= 0; b--) begin
		bb_pins(1'b1, 1'b0, cmd[b]);
		bb_pins(1'b1, 1'b1, cmd[b]);
	end
	bb_pins(1'b1, 1'b0, 1'b0);
	word = '0;
	for (int b = 15; b >= 0; b--) begin
		axi_read(REG_EECD, v);
		word[b] = v[EECD_DO];
		bb_pins(1'b1, 1'b1, 1'b0);
		bb_pins(1'b1, 1'b0, 1'b0);
	end
	if (word !== ee_ref[a])
		report_mismatch("bit-bang word", {16'h0, ee_ref[a]}, {16'h0, word});
	bb_pins(1'b0, 1'b0, 1'b0);
	axi_write(REG_EECD, 32'h0, 4'hF);
	r = $urandom;
	a = r[5:0];
	ee_read(a, v);
	if (v[EERD_DATA_LO +: 16] !== ee_ref[a])
		report_mismatch("EERD.DATA", {16'h0, ee_ref[a]}, {16'h0, v[EERD_DATA_LO +: 16]});
	finish_test();

	// 6: mixed traffic, EECD and unmapped space
	start_test("axi_mixed");
	eecd_sh = 3'b000;
	for (int i = 0; i < 40; i++) begin
		r = $urandom;
		w = {24'h0, r[7:2], 2'b00};
		if (w == REG_EECD || w == REG_EERD || w == REG_MDIC)
			w = REG_EECD;
		if (r[31]) begin
			d = r[23:8];
			exp = {$urandom};
			exp[EECD_REQ] = 1'b0;
			axi_write(w, exp, d[3:0]);
			if (w == REG_EECD && d[0])
				eecd_sh = {exp[EECD_DI], exp[EECD_CS], exp[EECD_SK]};
		end else begin
			axi_read(w, v);
			exp = (w == REG_EECD) ? {29'h0, eecd_sh} : 32'h0;
			// DO follows the pin, not compared
			if ((v & 32'hFFFF_FFF7) !== exp)
				report_mismatch("read data", exp, v);
		end
	end
	finish_test();

	$display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, total_errs);
	if (total_errs == 0)
		$display("Simulation passed");
	else
		$display("Simulation failed");
	$finish;
end

endmodule

// File: e1000_mgmt.f
common/e1000_reg_pkg.sv
common/e1000_serial_pkg.sv
regs/e1000_regs.sv
verilog/eeprom_shifter.sv
verilog/mdio_shifter.sv
verilog/e1000_mgmt_top.sv
bench/tb_clkgen.sv
bench/phy_eeprom_model.sv
bench/tb_e1000_mgmt.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= tb_e1000_mgmt
RTL_TOP ?= e1000_mgmt_top
FILELIST ?= e1000_mgmt.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
PASS_MSG ?= Simulation passed
VFLAGS ?= --timing --assert -sv

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(BUILD_DIR)/V$(TOP): $(shell cat $(FILELIST))
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
